// File: filelist.f
rtl/cpu_pkg.sv
rtl/inst_queue.sv
rtl/decoder.sv
rtl/rat.sv
rtl/free_list.sv
rtl/rob.sv
rtl/id_stage.sv
rtl/rename_top.sv
verif/rename_tb.sv

// File: verif/rename_tb.sv
module rename_tb;

    localparam int NUM_INST       = 400;
    localparam int TIMEOUT_CYCLES = 20 * NUM_INST + 200;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 fetch_valid;
    cpu_pkg::fetch_t      fetch_data;
    logic                 fetch_ready;
    logic                 rs_valid;
    cpu_pkg::uop_t        rs_uop;
    logic                 rs_ready;
    logic                 illegal;
    logic                 wb_valid;
    cpu_pkg::prf_idx_t    wb_phy;
    logic                 commit;
    logic                 commit_valid;
    cpu_pkg::rob_commit_t commit_data;

    // Shadow state of the front end
    cpu_pkg::fetch_t      iq_m [$];
    cpu_pkg::prf_idx_t    fl_m [$];
    cpu_pkg::rob_commit_t rob_m [$];
    cpu_pkg::prf_idx_t    wb_pending [$];
    cpu_pkg::prf_idx_t    map_m [cpu_pkg::ARF_NUM];
    logic                 rdy_m [cpu_pkg::ARF_NUM];
    cpu_pkg::rob_idx_t    next_rob;
    logic [31:0]          lfsr;
    logic                 fetch_taken;
    int                   sent;
    int                   consumed;
    int                   cycles;
    int                   uop_errs;
    int                   commit_errs;
    int                   flag_errs;

    rename_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .fetch_ready  (fetch_ready),
        .rs_valid     (rs_valid),
        .rs_uop       (rs_uop),
        .rs_ready     (rs_ready),
        .illegal      (illegal),
        .wb_valid     (wb_valid),
        .wb_phy       (wb_phy),
        .commit       (commit),
        .commit_valid (commit_valid),
        .commit_data  (commit_data)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic cpu_pkg::word_t take_bits(input int n);
        cpu_pkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Small register range so that dependencies are frequent
    function automatic cpu_pkg::word_t gen_inst();
        cpu_pkg::word_t w;
        logic [2:0]     kind;
        logic [2:0]     f3;
        logic [4:0]     rd;
        logic [4:0]     rs1;
        logic [4:0]     rs2;
        logic [6:0]     f7;
        logic [11:0]    imm;
        kind = 3'(take_bits(3));
        f3   = 3'(take_bits(3));
        rd   = 5'(take_bits(3));
        rs1  = 5'(take_bits(3));
        rs2  = 5'(take_bits(3));
        case (kind)
            3'd2, 3'd3: begin
                imm = 12'(take_bits(12));
                if (f3 == 3'd1) imm[11:5] = 7'h00;
                if (f3 == 3'd5) imm[11:5] = take_bits(1) ? 7'h20 : 7'h00;
                w = {imm, rs1, f3, rd, 7'b0010011};
            end
            3'd4: w = {20'(take_bits(20)), rd, 7'b0110111};
            3'd5: w = {20'(take_bits(20)), rd, 7'b0010111};
            3'd6: begin
                // Load, M extension, bad slli, or any word at all
                case (2'(take_bits(2)))
                    2'd0:    w = {12'(take_bits(12)), rs1, f3, rd, 7'b0000011};
                    2'd1:    w = {7'h01, rs2, rs1, f3, rd, 7'b0110011};
                    2'd2:    w = {7'h20, rs2, rs1, 3'd1, rd, 7'b0010011};
                    default: w = take_bits(32);
                endcase
            end
            default: begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && take_bits(1)) ? 7'h20 : 7'h00;
                w  = {f7, rs2, rs1, f3, rd, 7'b0110011};
            end
        endcase
        return w;
    endfunction

    //////////////////////////////
    // Reference decode
    //////////////////////////////

    function automatic cpu_pkg::uop_t ref_decode(input cpu_pkg::fetch_t f, output logic bad);
        cpu_pkg::uop_t u;
        logic [6:0]    f7;
        logic [2:0]    f3;
        u         = '0;
        u.pc      = f.pc;
        u.inst    = f.inst;
        u.rs_type = cpu_pkg::RS_INT;
        u.fu_op   = cpu_pkg::FU_ADD;
        u.op1_sel = cpu_pkg::OP_REG;
        u.op2_sel = cpu_pkg::OP_REG;
        f7        = f.inst[31:25];
        f3        = f.inst[14:12];
        bad       = 1'b0;
        case (f.inst[6:0])
            7'b0110011: begin
                case ({f7, f3})
                    {7'h00, 3'd0}: u.fu_op = cpu_pkg::FU_ADD;
                    {7'h20, 3'd0}: u.fu_op = cpu_pkg::FU_SUB;
                    {7'h00, 3'd1}: u.fu_op = cpu_pkg::FU_SLL;
                    {7'h00, 3'd2}: u.fu_op = cpu_pkg::FU_SLT;
                    {7'h00, 3'd3}: u.fu_op = cpu_pkg::FU_SLTU;
                    {7'h00, 3'd4}: u.fu_op = cpu_pkg::FU_XOR;
                    {7'h00, 3'd5}: u.fu_op = cpu_pkg::FU_SRL;
                    {7'h20, 3'd5}: u.fu_op = cpu_pkg::FU_SRA;
                    {7'h00, 3'd6}: u.fu_op = cpu_pkg::FU_OR;
                    {7'h00, 3'd7}: u.fu_op = cpu_pkg::FU_AND;
                    default:       bad = 1'b1;
                endcase
                u.rd_arch  = f.inst[11:7];
                u.rs1_arch = f.inst[19:15];
                u.rs2_arch = f.inst[24:20];
            end
            7'b0010011: begin
                case (f3)
                    3'd0: u.fu_op = cpu_pkg::FU_ADD;
                    3'd1: begin
                        u.fu_op = cpu_pkg::FU_SLL;
                        bad     = (f7 != 7'h00);
                    end
                    3'd2: u.fu_op = cpu_pkg::FU_SLT;
                    3'd3: u.fu_op = cpu_pkg::FU_SLTU;
                    3'd4: u.fu_op = cpu_pkg::FU_XOR;
                    3'd5: begin
                        u.fu_op = (f7 == 7'h20) ? cpu_pkg::FU_SRA : cpu_pkg::FU_SRL;
                        bad     = (f7 != 7'h00) && (f7 != 7'h20);
                    end
                    3'd6: u.fu_op = cpu_pkg::FU_OR;
                    default: u.fu_op = cpu_pkg::FU_AND;
                endcase
                u.op2_sel  = cpu_pkg::OP_IMM;
                u.imm      = {{20{f.inst[31]}}, f.inst[31:20]};
                u.rd_arch  = f.inst[11:7];
                u.rs1_arch = f.inst[19:15];
            end
            7'b0110111, 7'b0010111: begin
                // LUI passes the immediate, AUIPC adds it to the pc
                u.fu_op   = f.inst[5] ? cpu_pkg::FU_LUI : cpu_pkg::FU_ADD;
                u.op1_sel = f.inst[5] ? cpu_pkg::OP_REG : cpu_pkg::OP_PC;
                u.op2_sel = cpu_pkg::OP_IMM;
                u.imm     = {f.inst[31:12], 12'b0};
                u.rd_arch = f.inst[11:7];
            end
            default: bad = 1'b1;
        endcase
        return u;
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_uop(input cpu_pkg::uop_t got, input cpu_pkg::uop_t exp);
        if (got !== exp) begin
            uop_errs++;
            $display("FAIL t=%0t rs_uop got=%h exp=%h", $time, got, exp);
        end
    endtask

    task automatic check_commit(input cpu_pkg::rob_commit_t got,
                                input cpu_pkg::rob_commit_t exp);
        if (got !== exp) begin
            commit_errs++;
            $display("FAIL t=%0t commit_data got=%h exp=%h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    // Model step at the falling edge where outputs have settled
    task automatic model_cycle();
        cpu_pkg::uop_t        exp_uop;
        cpu_pkg::rob_commit_t exp_c;
        cpu_pkg::rob_commit_t rec;
        cpu_pkg::prf_idx_t    new_phy;
        cpu_pkg::arf_idx_t    ren_arch;
        logic                 bad;
        logic                 exp_disp;
        logic                 exp_ill;
        logic                 exp_cv;
        logic                 ren;
        exp_disp = 1'b0;
        exp_ill  = 1'b0;
        ren      = 1'b0;
        if (iq_m.size() > 0) begin
            exp_uop = ref_decode(iq_m[0], bad);
            exp_ill = bad;
            exp_disp = !bad && rs_ready && (rob_m.size() < cpu_pkg::ROB_DEPTH) &&
                       (exp_uop.rd_arch == '0 || fl_m.size() > 0);
        end
        exp_cv = commit && (rob_m.size() > 0);
        check_flag("fetch_ready", fetch_ready, iq_m.size() < cpu_pkg::IQ_DEPTH);
        check_flag("rs_valid", rs_valid, exp_disp);
        check_flag("illegal", illegal, exp_ill);
        check_flag("commit_valid", commit_valid, exp_cv);
        if (exp_cv && commit_valid) begin
            check_commit(commit_data, rob_m[0]);
        end
        if (exp_ill) begin
            void'(iq_m.pop_front());
            consumed++;
        end
        if (exp_disp) begin
            exp_uop.rd_phy    = (exp_uop.rd_arch != '0) ? fl_m[0] : '0;
            exp_uop.rs1_phy   = map_m[exp_uop.rs1_arch];
            exp_uop.rs1_ready = rdy_m[exp_uop.rs1_arch];
            exp_uop.rs2_phy   = map_m[exp_uop.rs2_arch];
            exp_uop.rs2_ready = rdy_m[exp_uop.rs2_arch];
            exp_uop.rob_id    = next_rob;
            if (rs_valid) begin
                check_uop(rs_uop, exp_uop);
            end
            rec.rd_arch = exp_uop.rd_arch;
            rec.old_phy = map_m[exp_uop.rd_arch];
            rob_m.push_back(rec);
            next_rob = next_rob + 1'b1;
            if (exp_uop.rd_arch != '0) begin
                void'(fl_m.pop_front());
                ren      = 1'b1;
                ren_arch = exp_uop.rd_arch;
                new_phy  = exp_uop.rd_phy;
                wb_pending.push_back(new_phy);
            end
            void'(iq_m.pop_front());
            consumed++;
        end
        if (exp_cv) begin
            exp_c = rob_m.pop_front();
            if (exp_c.old_phy != '0) fl_m.push_back(exp_c.old_phy);
        end
        // Writeback first so that a rename in the same cycle overrides it
        if (wb_valid) begin
            for (int i = 1; i < cpu_pkg::ARF_NUM; i++) begin
                if (map_m[i] == wb_phy) rdy_m[i] = 1'b1;
            end
        end
        if (ren) begin
            map_m[ren_arch] = new_phy;
            rdy_m[ren_arch] = 1'b0;
        end
        fetch_taken = fetch_valid && fetch_ready;
        if (fetch_taken) iq_m.push_back(fetch_data);
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            model_cycle();
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("errors: uop %0d, commit %0d, flag %0d", uop_errs, commit_errs, flag_errs);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        rs_ready    = 1'b0;
        wb_valid    = 1'b0;
        wb_phy      = '0;
        commit      = 1'b0;
        lfsr        = 32'h2e3f_84e0;
        fetch_taken = 1'b0;
        next_rob    = '0;
        sent        = 0;
        consumed    = 0;
        uop_errs    = 0;
        commit_errs = 0;
        flag_errs   = 0;
        for (int i = 0; i < cpu_pkg::ARF_NUM; i++) begin
            map_m[i] = cpu_pkg::prf_idx_t'(i);
            rdy_m[i] = 1'b1;
            fl_m.push_back(cpu_pkg::prf_idx_t'(cpu_pkg::ARF_NUM + i));
        end
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        while (consumed < NUM_INST || rob_m.size() != 0) begin
            @(posedge clk);
            #1;
            // Hold the word until the queue has taken it
            if (fetch_taken) fetch_valid = 1'b0;
            if (!fetch_valid && sent < NUM_INST && take_bits(3) != 0) begin
                fetch_data  = '{pc: 32'h0000_1000 + 32'(sent * 4), inst: gen_inst()};
                fetch_valid = 1'b1;
                sent++;
            end
            rs_ready = (take_bits(2) != 0);
            commit   = 1'(take_bits(1));
            if (wb_pending.size() > 0 && take_bits(1)) begin
                wb_valid = 1'b1;
                wb_phy   = wb_pending.pop_front();
            end else begin
                wb_valid = 1'b0;
                wb_phy   = '0;
            end
        end
        $display("errors: uop %0d, commit %0d, flag %0d", uop_errs, commit_errs, flag_errs);
        if (uop_errs + commit_errs + flag_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: rtl/rename_top.sv
module rename_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_valid,
    input  cpu_pkg::fetch_t      fetch_data,
    output logic                 fetch_ready,
    output logic                 rs_valid,
    output cpu_pkg::uop_t        rs_uop,
    input  logic                 rs_ready,
    output logic                 illegal,
    input  logic                 wb_valid,
    input  cpu_pkg::prf_idx_t    wb_phy,
    input  logic                 commit,
    output logic                 commit_valid,
    output cpu_pkg::rob_commit_t commit_data
);
    logic                iq_valid;
    cpu_pkg::fetch_t     iq_data;
    logic                iq_pop;
    cpu_pkg::arf_idx_t   rat_rd_arch [3];
    cpu_pkg::prf_idx_t   rat_rd_phy [3];
    logic                rat_rd_ready [2];
    logic                rat_wr_en;
    cpu_pkg::arf_idx_t   rat_wr_arch;
    cpu_pkg::prf_idx_t   rat_wr_phy;
    logic                fl_ready;
    cpu_pkg::prf_idx_t   fl_idx;
    logic                fl_pop;
    logic                rob_ready;
    cpu_pkg::rob_idx_t   rob_id;
    logic                rob_alloc_en;
    cpu_pkg::rob_alloc_t rob_alloc;

    inst_queue inst_queue_i (
        .clk       (clk),
        .rst       (rst),
        .push      (fetch_valid),
        .push_data (fetch_data),
        .full_n    (fetch_ready),
        .valid     (iq_valid),
        .head      (iq_data),
        .pop       (iq_pop)
    );

    id_stage id_stage_i (.*);

    rat rat_i (
        .clk      (clk),
        .rst      (rst),
        .rd_arch  (rat_rd_arch),
        .rd_phy   (rat_rd_phy),
        .rd_ready (rat_rd_ready),
        .wr_en    (rat_wr_en),
        .wr_arch  (rat_wr_arch),
        .wr_phy   (rat_wr_phy),
        .wb_valid (wb_valid),
        .wb_phy   (wb_phy)
    );

    // Retired mappings flow back into the free list
    free_list free_list_i (
        .clk      (clk),
        .rst      (rst),
        .pop      (fl_pop),
        .ready    (fl_ready),
        .idx      (fl_idx),
        .push     (commit_valid),
        .push_idx (commit_data.old_phy)
    );

    rob rob_i (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (rob_alloc_en),
        .alloc        (rob_alloc),
        .ready        (rob_ready),
        .tail_id      (rob_id),
        .commit       (commit),
        .commit_valid (commit_valid),
        .commit_data  (commit_data)
    );

endmodule

// File: rtl/id_stage.sv
module id_stage (
    input  logic                iq_valid,
    input  cpu_pkg::fetch_t     iq_data,
    output logic                iq_pop,
    output cpu_pkg::arf_idx_t   rat_rd_arch [3],
    input  cpu_pkg::prf_idx_t   rat_rd_phy [3],
    input  logic                rat_rd_ready [2],
    output logic                rat_wr_en,
    output cpu_pkg::arf_idx_t   rat_wr_arch,
    output cpu_pkg::prf_idx_t   rat_wr_phy,
    input  logic                fl_ready,
    input  cpu_pkg::prf_idx_t   fl_idx,
    output logic                fl_pop,
    input  logic                rob_ready,
    input  cpu_pkg::rob_idx_t   rob_id,
    output logic                rob_alloc_en,
    output cpu_pkg::rob_alloc_t rob_alloc,
    output logic                rs_valid,
    output cpu_pkg::uop_t       rs_uop,
    input  logic                rs_ready,
    output logic                illegal
);
    cpu_pkg::rs_type_e rs_type;
    cpu_pkg::fu_op_e   fu_op;
    cpu_pkg::op_sel_e  op1_sel;
    cpu_pkg::op_sel_e  op2_sel;
    cpu_pkg::word_t    imm;
    cpu_pkg::arf_idx_t rd_arch;
    cpu_pkg::arf_idx_t rs1_arch;
    cpu_pkg::arf_idx_t rs2_arch;
    cpu_pkg::prf_idx_t rd_phy;
    logic              inst_invalid;
    logic              needs_rd;
    logic              rs_ok;
    logic              dispatch;

    decoder decoder_i (
        .inst (iq_data.inst),
        .*
    );

    //////////////////////////////
    // Consume condition
    //////////////////////////////

    assign needs_rd = (rd_arch != '0);
    assign rs_ok    = (rs_type != cpu_pkg::RS_INT) || rs_ready;
    assign dispatch = iq_valid && !inst_invalid && rob_ready && rs_ok && (!needs_rd || fl_ready);
    // Illegal words leave the queue without waiting on anything
    assign illegal  = iq_valid && inst_invalid;
    assign iq_pop   = dispatch || illegal;

    // Rename lookups with the rd slot giving the mapping being replaced
    assign rat_rd_arch[0] = rs1_arch;
    assign rat_rd_arch[1] = rs2_arch;
    assign rat_rd_arch[2] = rd_arch;

    assign rd_phy      = needs_rd ? fl_idx : '0;
    assign fl_pop      = dispatch && needs_rd;
    assign rat_wr_en   = dispatch && needs_rd;
    assign rat_wr_arch = rd_arch;
    assign rat_wr_phy  = fl_idx;

    assign rob_alloc_en = dispatch;
    assign rob_alloc    = '{rd_arch: rd_arch, rd_phy: rd_phy, old_phy: rat_rd_phy[2]};

    assign rs_valid = dispatch && (rs_type == cpu_pkg::RS_INT);
    assign rs_uop   = '{pc:        iq_data.pc,
                        inst:      iq_data.inst,
                        rs_type:   rs_type,
                        fu_op:     fu_op,
                        op1_sel:   op1_sel,
                        op2_sel:   op2_sel,
                        imm:       imm,
                        rd_arch:   rd_arch,
                        rs1_arch:  rs1_arch,
                        rs2_arch:  rs2_arch,
                        rd_phy:    rd_phy,
                        rs1_phy:   rat_rd_phy[0],
                        rs1_ready: rat_rd_ready[0],
                        rs2_phy:   rat_rd_phy[1],
                        rs2_ready: rat_rd_ready[1],
                        rob_id:    rob_id};

endmodule

// File: rtl/rob.sv
module rob (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc_en,
    input  cpu_pkg::rob_alloc_t  alloc,
    output logic                 ready,
    output cpu_pkg::rob_idx_t    tail_id,
    input  logic                 commit,
    output logic                 commit_valid,
    output cpu_pkg::rob_commit_t commit_data
);
    cpu_pkg::rob_commit_t mem [cpu_pkg::ROB_DEPTH];
    cpu_pkg::rob_idx_t    head_q;
    cpu_pkg::rob_idx_t    tail_q;
    logic [cpu_pkg::ROB_IDX:0] count_q;
    logic                 do_alloc;

    assign ready    = (count_q != (cpu_pkg::ROB_IDX + 1)'(cpu_pkg::ROB_DEPTH));
    assign tail_id  = tail_q;
    assign do_alloc = alloc_en && ready;

    // Commit is ignored on an empty ROB
    assign commit_valid = commit && (count_q != '0);
    assign commit_data  = mem[head_q];

    // Rename records
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            mem[tail_q] <= '{rd_arch: alloc.rd_arch, old_phy: alloc.old_phy};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_alloc) begin
                tail_q <= tail_q + 1'b1;
            end
            if (commit_valid) begin
                head_q <= head_q + 1'b1;
            end
            case ({do_alloc, commit_valid})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: rtl/free_list.sv
module free_list (
    input  logic              clk,
    input  logic              rst,
    input  logic              pop,
    output logic              ready,
    output cpu_pkg::prf_idx_t idx,
    input  logic              push,
    input  cpu_pkg::prf_idx_t push_idx
);
    cpu_pkg::prf_idx_t          mem [cpu_pkg::FL_DEPTH];
    logic [cpu_pkg::FL_IDX-1:0] head_q;
    logic [cpu_pkg::FL_IDX-1:0] tail_q;
    logic [cpu_pkg::FL_IDX:0]   count_q;
    logic                       do_push;
    logic                       do_pop;

    assign ready   = (count_q != '0);
    assign idx     = mem[head_q];
    assign do_pop  = pop && ready;
    // Phys 0 belongs to x0 and never circulates
    assign do_push = push && (push_idx != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // Starts full with every unmapped register
            for (int i = 0; i < cpu_pkg::FL_DEPTH; i++) begin
                mem[i] <= cpu_pkg::prf_idx_t'(cpu_pkg::ARF_NUM + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (cpu_pkg::FL_IDX + 1)'(cpu_pkg::FL_DEPTH);
        end else begin
            if (do_push) begin
                mem[tail_q] <= push_idx;
                tail_q      <= tail_q + 1'b1;
            end
            if (do_pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: rtl/rat.sv
module rat (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::arf_idx_t rd_arch [3],
    output cpu_pkg::prf_idx_t rd_phy [3],
    output logic              rd_ready [2],
    input  logic              wr_en,
    input  cpu_pkg::arf_idx_t wr_arch,
    input  cpu_pkg::prf_idx_t wr_phy,
    input  logic              wb_valid,
    input  cpu_pkg::prf_idx_t wb_phy
);
    cpu_pkg::prf_idx_t map_q [cpu_pkg::ARF_NUM];
    logic              ready_q [cpu_pkg::ARF_NUM];

    // x0 is hardwired to phys 0 and always ready
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            rd_phy[r] = (rd_arch[r] == '0) ? '0 : map_q[rd_arch[r]];
        end
        for (int r = 0; r < 2; r++) begin
            rd_ready[r] = (rd_arch[r] == '0) || ready_q[rd_arch[r]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpu_pkg::ARF_NUM; i++) begin
                map_q[i]   <= cpu_pkg::prf_idx_t'(i);
                ready_q[i] <= 1'b1;
            end
        end else begin
            for (int i = 1; i < cpu_pkg::ARF_NUM; i++) begin
                // New rename beats a writeback to the old mapping
                if (wr_en && wr_arch == cpu_pkg::arf_idx_t'(i)) begin
                    map_q[i]   <= wr_phy;
                    ready_q[i] <= 1'b0;
                end else if (wb_valid && map_q[i] == wb_phy) begin
                    ready_q[i] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/decoder.sv
module decoder (
    input  cpu_pkg::word_t    inst,
    output cpu_pkg::rs_type_e rs_type,
    output cpu_pkg::fu_op_e   fu_op,
    output cpu_pkg::op_sel_e  op1_sel,
    output cpu_pkg::op_sel_e  op2_sel,
    output cpu_pkg::word_t    imm,
    output cpu_pkg::arf_idx_t rd_arch,
    output cpu_pkg::arf_idx_t rs1_arch,
    output cpu_pkg::arf_idx_t rs2_arch,
    output logic              inst_invalid
);
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            f7_zero;
    logic            f7_alt;
    cpu_pkg::word_t  imm_i;
    cpu_pkg::word_t  imm_u;
    cpu_pkg::fu_op_e base_op;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign f7_zero = (inst[31:25] == 7'b0000000);
    assign f7_alt  = (inst[31:25] == 7'b0100000);
    assign imm_i   = {{20{inst[31]}}, inst[31:20]};
    assign imm_u   = {inst[31:12], 12'b0};

    // ALU op from funct3 alone for both OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  base_op = cpu_pkg::FU_ADD;
            3'b001:  base_op = cpu_pkg::FU_SLL;
            3'b010:  base_op = cpu_pkg::FU_SLT;
            3'b011:  base_op = cpu_pkg::FU_SLTU;
            3'b100:  base_op = cpu_pkg::FU_XOR;
            3'b101:  base_op = cpu_pkg::FU_SRL;
            3'b110:  base_op = cpu_pkg::FU_OR;
            default: base_op = cpu_pkg::FU_AND;
        endcase
    end

    always_comb begin
        // Defaults describe an illegal word with no registers
        rs_type      = cpu_pkg::RS_NONE;
        fu_op        = cpu_pkg::FU_ADD;
        op1_sel      = cpu_pkg::OP_REG;
        op2_sel      = cpu_pkg::OP_REG;
        imm          = '0;
        rd_arch      = '0;
        rs1_arch     = '0;
        rs2_arch     = '0;
        inst_invalid = 1'b1;

        case (opcode)
            cpu_pkg::OPC_OP: begin
                // Only sub and sra accept the alternate funct7
                if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    inst_invalid = 1'b0;
                    rs_type      = cpu_pkg::RS_INT;
                    fu_op        = base_op;
                    if (f7_alt) begin
                        fu_op = (funct3 == 3'b000) ? cpu_pkg::FU_SUB : cpu_pkg::FU_SRA;
                    end
                    rd_arch  = inst[11:7];
                    rs1_arch = inst[19:15];
                    rs2_arch = inst[24:20];
                end
            end
            cpu_pkg::OPC_OP_IMM: begin
                // Shift immediates check the upper bits of the word
                if ((funct3 == 3'b001 && f7_zero) ||
                    (funct3 == 3'b101 && (f7_zero || f7_alt)) ||
                    (funct3 != 3'b001 && funct3 != 3'b101)) begin
                    inst_invalid = 1'b0;
                    rs_type      = cpu_pkg::RS_INT;
                    fu_op        = base_op;
                    if (funct3 == 3'b101 && f7_alt) begin
                        fu_op = cpu_pkg::FU_SRA;
                    end
                    op2_sel  = cpu_pkg::OP_IMM;
                    imm      = imm_i;
                    rd_arch  = inst[11:7];
                    rs1_arch = inst[19:15];
                end
            end
            cpu_pkg::OPC_LUI: begin
                inst_invalid = 1'b0;
                rs_type      = cpu_pkg::RS_INT;
                fu_op        = cpu_pkg::FU_LUI;
                op2_sel      = cpu_pkg::OP_IMM;
                imm          = imm_u;
                rd_arch      = inst[11:7];
            end
            cpu_pkg::OPC_AUIPC: begin
                inst_invalid = 1'b0;
                rs_type      = cpu_pkg::RS_INT;
                fu_op        = cpu_pkg::FU_ADD;
                op1_sel      = cpu_pkg::OP_PC;
                op2_sel      = cpu_pkg::OP_IMM;
                imm          = imm_u;
                rd_arch      = inst[11:7];
            end
            default: begin
                inst_invalid = 1'b1;
            end
        endcase
    end

endmodule

// File: rtl/inst_queue.sv
module inst_queue (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  cpu_pkg::fetch_t push_data,
    output logic            full_n,
    output logic            valid,
    output cpu_pkg::fetch_t head,
    input  logic            pop
);
    cpu_pkg::fetch_t              mem [cpu_pkg::IQ_DEPTH];
    logic [cpu_pkg::IQ_IDX-1:0]   head_q;
    logic [cpu_pkg::IQ_IDX-1:0]   tail_q;
    logic [cpu_pkg::IQ_IDX:0]     count_q;
    logic                         do_push;
    logic                         do_pop;

    assign full_n  = (count_q != (cpu_pkg::IQ_IDX + 1)'(cpu_pkg::IQ_DEPTH));
    assign valid   = (count_q != '0);
    assign head    = mem[head_q];
    assign do_push = push && full_n;
    assign do_pop  = pop && valid;

    // Payload storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail_q] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (do_pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: rtl/cpu_pkg.sv
package cpu_pkg;

    //////////////////////////////
    // Widths and depths
    //////////////////////////////

    localparam int ARF_IDX   = 5;
    localparam int ARF_NUM   = 32;
    localparam int PRF_IDX   = 6;
    localparam int PRF_NUM   = 64;
    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX   = 4;
    localparam int IQ_DEPTH  = 8;
    localparam int IQ_IDX    = 3;
    // Physical registers not mapped at reset
    localparam int FL_DEPTH  = PRF_NUM - ARF_NUM;
    localparam int FL_IDX    = 5;

    // RV32I major opcodes handled here
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef logic [ARF_IDX-1:0] arf_idx_t;
    typedef logic [PRF_IDX-1:0] prf_idx_t;
    typedef logic [ROB_IDX-1:0] rob_idx_t;
    typedef logic [31:0]        word_t;

    typedef enum logic {
        RS_INT,
        RS_NONE
    } rs_type_e;

    typedef enum logic [3:0] {
        FU_ADD  = 4'd0,
        FU_SUB  = 4'd1,
        FU_SLL  = 4'd2,
        FU_SLT  = 4'd3,
        FU_SLTU = 4'd4,
        FU_XOR  = 4'd5,
        FU_SRL  = 4'd6,
        FU_SRA  = 4'd7,
        FU_OR   = 4'd8,
        FU_AND  = 4'd9,
        FU_LUI  = 4'd10
    } fu_op_e;

    typedef enum logic [1:0] {
        OP_REG,
        OP_IMM,
        OP_PC
    } op_sel_e;

    //////////////////////////////
    // Structs
    //////////////////////////////

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_t;

    typedef struct packed {
        word_t    pc;
        word_t    inst;
        rs_type_e rs_type;
        fu_op_e   fu_op;
        op_sel_e  op1_sel;
        op_sel_e  op2_sel;
        word_t    imm;
        arf_idx_t rd_arch;
        arf_idx_t rs1_arch;
        arf_idx_t rs2_arch;
        prf_idx_t rd_phy;
        prf_idx_t rs1_phy;
        logic     rs1_ready;
        prf_idx_t rs2_phy;
        logic     rs2_ready;
        rob_idx_t rob_id;
    } uop_t;

    typedef struct packed {
        arf_idx_t rd_arch;
        prf_idx_t rd_phy;
        prf_idx_t old_phy;
    } rob_alloc_t;

    typedef struct packed {
        arf_idx_t rd_arch;
        prf_idx_t old_phy;
    } rob_commit_t;

endpackage
